//--- Bender.yml
package:
  name: ppu_bg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ppu_types_pkg.sv
      - rtl/ppu_regs_pkg.sv
      - rtl/ppu_ifs.sv
      - rtl/lcd_regs.sv
      - rtl/lcd_timing.sv
      - rtl/bg_fetcher.sv
      - rtl/pixel_shifter.sv
      - rtl/ppu_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/ppu_properties.sv
      - dv/ppu_tb.sv

//--- dv/ppu_properties.sv
// bound checks for mode order, V-blank pulse width and the tile handshake; unused inputs tie low
`timescale 1ns/100ps

module ppu_properties
    import ppu_types_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [1:0] mode,
    input logic       irq_vblank,
    input logic       tile_ready,
    input logic       tile_take,
    input logic [7:0] row_lo,
    input logic [7:0] row_hi
);

    int fail_cnt = 0;   // assertion failures so far

    no_hblank_to_draw: assert property (@(posedge clk) disable iff (rst)
        mode == H_BLANK |=> mode != DRAW)
        else begin
            $error("mode went from H_BLANK straight to DRAW");
            fail_cnt++;
        end

    vblank_one_cycle: assert property (@(posedge clk) disable iff (rst)
        irq_vblank |=> !irq_vblank)
        else begin
            $error("irq_vblank lasted more than one cycle");
            fail_cnt++;
        end

    // rows must not move while the shifter has not taken them
    tile_held: assert property (@(posedge clk) disable iff (rst)
        tile_ready && !tile_take |=> tile_ready && $stable(row_lo) && $stable(row_hi))
        else begin
            $error("tile_ready dropped or rows changed before tile_take");
            fail_cnt++;
        end

endmodule

bind lcd_timing ppu_properties u_timing_props (
    .clk(clk), .rst(rst), .mode(mode), .irq_vblank(irq_vblank),
    .tile_ready(1'b0), .tile_take(1'b0), .row_lo(8'h00), .row_hi(8'h00)
);

bind bg_fetcher ppu_properties u_fetch_props (
    .clk(clk), .rst(rst), .mode(line.mode), .irq_vblank(1'b0),
    .tile_ready(tile_ready), .tile_take(tile.tile_take), .row_lo(row_lo), .row_hi(row_hi)
);

//--- dv/ppu_tb.sv
// background path testbench; register changes only happen with the LCD off or in V_BLANK
`timescale 1ns/100ps
`include "ppu_macros.svh"

module ppu_tb import ppu_types_pkg::*; import ppu_regs_pkg::*; ();

    localparam int FRAMES_TESTED = 7;
    localparam int FRAME_CYCLES  = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] addr;
    logic        wr, rd;
    logic [7:0]  wdata, rdata;
    logic        irq_vblank, irq_stat, vram_rd, px_valid;
    logic [1:0]  mode, px;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data;
    logic [7:0]  vram [0:8191];
    logic [31:0] lfsr = 32'h73df;
    logic [7:0]  lcdc_q = 8'h00, scx_q = 8'h00, scy_q = 8'h00, lyc_q = 8'h00;
    logic [7:0]  rd_val, exp_val;
    int          cur_dot = 0, cur_ly = 0, xcnt = 0, rd_cnt = 0, snap_ly, last_ly;
    bit          prev_on = 0, seen_wrap;
    int          errors = 0, tests = 0, tests_failed = 0, err_start;
    int          vblank_cnt, stat_cnt, px_cnt;
    string       cur_test = "reset";

    always #2 clk = ~clk;
    assign vram_data = vram[vram_addr[12:0]];   // 8000-9FFF folded onto 8 KiB

    ppu_top dut (.*);

    function automatic logic [7:0] rand_bits(int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);   // galois step
        end
        return v;
    endfunction

    function automatic logic [1:0] expected_px(int x, int ly);
        logic [7:0]  y, num, lo, hi;
        logic [4:0]  col;
        logic [15:0] map_a, row_a;
        int          b;
        y     = 8'(ly + scy_q);
        col   = 5'(scx_q[7:3] + x / 8);
        map_a = (lcdc_q[`LCDC_MAP_SEL] ? `PPU_BG_MAP_HI : `PPU_BG_MAP_LO) + 16'(32 * y[7:3]) + col;
        num   = vram[map_a[12:0]];
        if (lcdc_q[`LCDC_TILE_SEL])
            row_a = `PPU_TILE_BASE_UNSIGNED + 16'(16 * num);
        else
            row_a = 16'(int'(`PPU_TILE_BASE_SIGNED) + 16 * int'($signed(num)));
        row_a = row_a + 16'(2 * y[2:0]);
        lo    = vram[row_a[12:0]];
        hi    = vram[13'(row_a + 16'd1)];
        b     = 7 - x % 8;   // msb is the leftmost pixel
        if (!lcdc_q[`LCDC_BG_ENABLE])
            return 2'b00;
        return {hi[b], lo[b]};
    endfunction

    task automatic check(string what, logic [7:0] exp, logic [7:0] got);
        assert (exp === got) else begin
            $display("error %s %s: expected %h actual %h", cur_test, what, exp, got);
            errors++;
        end
    endtask

    task automatic write_reg(logic [15:0] a, logic [7:0] d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(posedge clk);
        case (a)   // shadow copy used by the reference model
            REG_LCDC: lcdc_q = d;
            REG_SCX:  scx_q  = d;
            REG_SCY:  scy_q  = d;
            REG_LYC:  lyc_q  = d;
            default: ;
        endcase
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_reg(logic [15:0] a);
        @(negedge clk);
        addr = a;
        rd   = 1'b1;
        #1;
        rd_val  = rdata;
        snap_ly = cur_ly;
        @(negedge clk);
        rd = 1'b0;
    endtask

    task automatic wait_vblank(int n);
        repeat (n) begin
            @(negedge clk);
            while (!irq_vblank) @(negedge clk);
        end
    endtask

    task automatic begin_test(string name);
        cur_test   = name;
        err_start  = errors;
        vblank_cnt = 0;
        stat_cnt   = 0;
        px_cnt     = 0;
    endtask

    task automatic end_test();
        tests++;
        if (errors != err_start) tests_failed++;
        $display("%s: %s", cur_test, (errors == err_start) ? "ok" : "failed");
    endtask

    // one visible frame with random scroll, LCD switched off again in V_BLANK
    task automatic run_frame(logic [7:0] lcdc);
        write_reg(REG_SCY, rand_bits(8));
        write_reg(REG_SCX, rand_bits(8));
        write_reg(REG_LCDC, lcdc);
        wait_vblank(1);
        write_reg(REG_LCDC, 8'h00);
        check("pixel lines", 8'(`PPU_VISIBLE_LINES), 8'(px_cnt / 160));
        check("pixel remainder", 8'd0, 8'(px_cnt % 160));
    endtask

    // line tracker and pixel compare
    always @(negedge clk) begin
        if (rst || !lcdc_q[`LCDC_ENABLE]) begin
            cur_dot = 0;
            cur_ly  = 0;
            prev_on = 0;
        end else if (!prev_on) begin
            cur_dot = 0;
            cur_ly  = 0;
            prev_on = 1;
        end else if (cur_dot == `PPU_DOTS_PER_LINE - 1) begin
            cur_dot = 0;
            cur_ly  = (cur_ly == `PPU_LINES_PER_FRAME - 1) ? 0 : cur_ly + 1;
        end else begin
            cur_dot++;
        end
        if (cur_dot == 0) begin
            xcnt   = 0;
            rd_cnt = 0;
        end
        if (irq_vblank) begin
            vblank_cnt++;
            assert (cur_ly == 144 && cur_dot == 0) else begin
                $display("error %s: irq_vblank at line %0d dot %0d", cur_test, cur_ly, cur_dot);
                errors++;
            end
        end
        if (irq_stat) begin
            stat_cnt++;
            assert (lcdc_q[`LCDC_ENABLE] && cur_ly == lyc_q) else begin
                $display("error %s: irq_stat outside the LYC line, at line %0d", cur_test, cur_ly);
                errors++;
            end
        end
        if (vram_rd) begin
            rd_cnt++;
            assert (mode == DRAW) else begin
                $display("error %s: vram_rd high outside DRAW at line %0d dot %0d", cur_test,
                         cur_ly, cur_dot);
                errors++;
            end
        end
        if (px_valid) begin
            px_cnt++;
            assert (cur_ly < `PPU_VISIBLE_LINES && xcnt < `PPU_SCREEN_WIDTH) else begin
                $display("error %s: pixel outside the visible area at line %0d", cur_test, cur_ly);
                errors++;
            end
            assert (px === expected_px(xcnt, cur_ly)) else begin
                $display("error %s px line %0d x %0d: expected %0d actual %0d", cur_test,
                         cur_ly, xcnt, expected_px(xcnt, cur_ly), px);
                errors++;
            end
            xcnt++;
        end
        if (lcdc_q[`LCDC_ENABLE] && cur_dot == `PPU_DOTS_PER_LINE - 1 && cur_ly < 144) begin
            assert (xcnt == `PPU_SCREEN_WIDTH) else begin
                $display("error %s line %0d pixels: expected 160 actual %0d", cur_test,
                         cur_ly, xcnt);
                errors++;
            end
            // three reads per tile, twenty tiles per line
            assert (rd_cnt == 3 * `PPU_SCREEN_WIDTH / 8) else begin
                $display("error %s line %0d vram reads: expected %0d actual %0d", cur_test,
                         cur_ly, 3 * `PPU_SCREEN_WIDTH / 8, rd_cnt);
                errors++;
            end
        end
        if (lcdc_q[`LCDC_ENABLE] && (cur_ly >= 144 || cur_dot < `PPU_SCAN_DOTS))
            assert (mode == ((cur_ly >= 144) ? V_BLANK : SCAN)) else begin
                $display("error %s mode at line %0d dot %0d: expected %0d actual %0d", cur_test,
                         cur_ly, cur_dot, (cur_ly >= 144) ? V_BLANK : SCAN, mode);
                errors++;
            end
    end

    initial begin
        #(real'(FRAMES_TESTED * FRAME_CYCLES) * 4.0 * 1.1);
        $display("watchdog: the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst   = 1'b1;
        addr  = 16'h0000;
        wr    = 1'b0;
        rd    = 1'b0;
        wdata = 8'h00;
        for (int a = 0; a < 8192; a++) vram[a] = rand_bits(8);
        repeat (16) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        begin_test("registers");
        for (int i = 0; i < 12; i++) write_reg(16'hFF40 + 16'(i), 8'(8'h11 + 8'h13 * i));
        for (int i = 0; i < 12; i++) begin
            wdata   = 8'(8'h11 + 8'h13 * i);   // value written above
            exp_val = (i == 4) ? 8'h00 : wdata;
            if (i == 1) exp_val = {1'b1, wdata[6:3], lyc_q == 8'h00, 2'b00};
            read_reg(16'hFF40 + 16'(i));
            check($sformatf("reg %h", 16'hFF40 + i), exp_val, rd_val);
        end
        read_reg(16'hFF4C);
        check("unmapped", 8'hFF, rd_val);
        write_reg(REG_STAT, 8'h00);
        end_test();

        begin_test("frame timing");
        write_reg(REG_LCDC, 8'h91);
        last_ly   = 0;
        seen_wrap = 0;
        while (vblank_cnt < 2) begin
            repeat (450) @(negedge clk);
            read_reg(REG_LY);
            check("LY", 8'(snap_ly), rd_val);
            if (snap_ly < last_ly && last_ly == 153) seen_wrap = 1;
            last_ly = snap_ly;
        end
        write_reg(REG_LCDC, 8'h00);
        check("vblank count", 8'd2, 8'(vblank_cnt));
        check("LY wrap", 8'd1, 8'(seen_wrap));
        end_test();

        begin_test("unsigned tiles, map 9800");
        run_frame(8'h91);
        end_test();

        begin_test("signed tiles, map 9C00");
        run_frame(8'h89);
        end_test();

        begin_test("stat interrupt");
        write_reg(REG_LYC, 8'd50);
        write_reg(REG_STAT, 8'h40);
        write_reg(REG_LCDC, 8'h91);
        while (vblank_cnt < 2) begin
            repeat (450) @(negedge clk);
            read_reg(REG_STAT);
            check($sformatf("STAT match line %0d", snap_ly), {1'b1, snap_ly == 50},
                  {rd_val[7], rd_val[2]});
        end
        write_reg(REG_LCDC, 8'h00);
        check("irq_stat count", 8'd2, 8'(stat_cnt));
        stat_cnt = 0;
        px_cnt   = 0;
        write_reg(REG_STAT, 8'h48);   // h_blank enable, mode reads H_BLANK while off
        repeat (2000) @(negedge clk);
        check("irq_stat with LCD off", 8'd0, 8'(stat_cnt));
        check("px_valid with LCD off", 8'd0, 8'(px_cnt));
        check("mode with LCD off", 8'd0, {6'd0, mode});
        read_reg(REG_LY);
        check("LY with LCD off", 8'd0, rd_val);
        write_reg(REG_STAT, 8'h00);
        end_test();

        begin_test("background disabled");
        run_frame(8'h90);
        end_test();

        errors = errors + dut.u_timing.u_timing_props.fail_cnt
                 + dut.u_fetcher.u_fetch_props.fail_cnt;
        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/bg_fetcher.sv
// background tile fetcher; coarse scx only, fetches exactly one screen width of tiles per line
`timescale 1ns/100ps
`include "ppu_macros.svh"

module bg_fetcher
    import ppu_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    ppu_cfg_if.sink     cfg,
    line_if.sink        line,
    tile_if.source      tile,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data
);

    localparam int TILES_PER_LINE = `PPU_SCREEN_WIDTH / 8;

    fetch_step_e step;
    logic [4:0]  col;         // map column, wraps at 32
    logic [4:0]  fetched;     // tiles fetched this line
    logic [7:0]  tile_num;
    logic [7:0]  row_lo;
    logic [7:0]  row_hi;
    logic        tile_ready;
    logic [7:0]  y;
    logic        bg_on;
    logic [15:0] map_base;
    logic [15:0] map_addr;
    logic [15:0] row_base;
    logic [15:0] lo_addr;

    assign y        = line.ly + cfg.scy;   // wraps mod 256
    assign bg_on    = cfg.lcdc[`LCDC_BG_ENABLE];
    assign map_base = cfg.lcdc[`LCDC_MAP_SEL] ? `PPU_BG_MAP_HI : `PPU_BG_MAP_LO;
    assign map_addr = map_base + {6'b0, y[7:3], col};

    always_comb begin
        if (cfg.lcdc[`LCDC_TILE_SEL])
            row_base = `PPU_TILE_BASE_UNSIGNED + {4'b0, tile_num, 4'b0};
        else   // signed tile number around 9000
            row_base = `PPU_TILE_BASE_SIGNED + {{4{tile_num[7]}}, tile_num, 4'b0};
    end

    assign lo_addr = row_base + {12'b0, y[2:0], 1'b0};

    always_comb begin
        case (step)
            LO_READ: vram_addr = lo_addr;
            HI_READ: vram_addr = lo_addr + 16'd1;
            default: vram_addr = map_addr;
        endcase
    end

    assign vram_rd = (step != TILE_HOLD);

    always_ff @(posedge clk) begin
        if (rst) begin
            step       <= TILE_HOLD;
            tile_ready <= 1'b0;
            col        <= '0;
            fetched    <= '0;
        end else if (line.draw_start) begin
            step       <= MAP_READ;
            tile_ready <= 1'b0;
            col        <= cfg.scx[7:3];
            fetched    <= '0;
        end else if (line.mode != DRAW) begin
            step       <= TILE_HOLD;   // idle outside DRAW
            tile_ready <= 1'b0;
        end else begin
            case (step)
                MAP_READ: step <= LO_READ;
                LO_READ:  step <= HI_READ;
                HI_READ: begin
                    step       <= TILE_HOLD;
                    tile_ready <= 1'b1;
                    col        <= col + 5'd1;
                    fetched    <= fetched + 5'd1;
                end
                default: begin
                    if (tile_ready && tile.tile_take) begin
                        tile_ready <= 1'b0;
                        if (fetched != 5'(TILES_PER_LINE))
                            step <= MAP_READ;
                    end
                end
            endcase
        end
    end

    // data captures, the rows stay put while tile_ready is high
    always_ff @(posedge clk) begin
        case (step)
            MAP_READ: tile_num <= vram_data;
            LO_READ:  row_lo   <= bg_on ? vram_data : 8'h00;
            HI_READ:  row_hi   <= bg_on ? vram_data : 8'h00;
            default: ;
        endcase
    end

    assign tile.row_lo     = row_lo;
    assign tile.row_hi     = row_hi;
    assign tile.tile_ready = tile_ready;

endmodule

//--- rtl/lcd_regs.sv
// lcd registers FF40-FF4B; reads are combinational and return 00 while rd is low
`timescale 1ns/100ps
`include "ppu_macros.svh"

module lcd_regs
    import ppu_types_pkg::*;
    import ppu_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        irq_stat,
    ppu_cfg_if.source   cfg,
    line_if.sink        line
);

    logic [7:0] lcdc_r, scy_r, scx_r, lyc_r, dma_r;
    logic [7:0] bgp_r, obp0_r, obp1_r, wy_r, wx_r;
    logic [6:3] stat_ie_r;   // only the enable bits are writable
    logic       lyc_match;
    logic       stat_cond;
    logic       stat_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc_r    <= REG_RESET_LCDC;
            stat_ie_r <= REG_RESET_STAT[6:3];
            scy_r     <= REG_RESET_SCY;
            scx_r     <= REG_RESET_SCX;
            lyc_r     <= REG_RESET_LYC;
            dma_r     <= REG_RESET_DMA;
            bgp_r     <= REG_RESET_BGP;
            obp0_r    <= REG_RESET_OBP0;
            obp1_r    <= REG_RESET_OBP1;
            wy_r      <= REG_RESET_WY;
            wx_r      <= REG_RESET_WX;
            stat_q    <= 1'b0;
        end else begin
            stat_q <= stat_cond;
            if (wr) begin
                case (addr)
                    REG_LCDC: lcdc_r    <= wdata;
                    REG_STAT: stat_ie_r <= wdata[6:3];
                    REG_SCY:  scy_r     <= wdata;
                    REG_SCX:  scx_r     <= wdata;
                    REG_LYC:  lyc_r     <= wdata;
                    REG_DMA:  dma_r     <= wdata;
                    REG_BGP:  bgp_r     <= wdata;
                    REG_OBP0: obp0_r    <= wdata;
                    REG_OBP1: obp1_r    <= wdata;
                    REG_WY:   wy_r      <= wdata;
                    REG_WX:   wx_r      <= wdata;
                    default: ;   // LY and unmapped addresses ignore writes
                endcase
            end
        end
    end

    assign lyc_match = (line.ly == lyc_r);

    always_comb begin
        rdata = 8'h00;
        if (rd) begin
            case (addr)
                REG_LCDC: rdata = lcdc_r;
                REG_STAT: rdata = {1'b1, stat_ie_r, lyc_match, line.mode};
                REG_SCY:  rdata = scy_r;
                REG_SCX:  rdata = scx_r;
                REG_LY:   rdata = line.ly;
                REG_LYC:  rdata = lyc_r;
                REG_DMA:  rdata = dma_r;
                REG_BGP:  rdata = bgp_r;
                REG_OBP0: rdata = obp0_r;
                REG_OBP1: rdata = obp1_r;
                REG_WY:   rdata = wy_r;
                REG_WX:   rdata = wx_r;
                default:  rdata = 8'hFF;
            endcase
        end
    end

    // combined stat line, only live while the lcd runs
    assign stat_cond = cfg.lcdc[`LCDC_ENABLE] &&
                       ((cfg.stat_ie[`STAT_LYC_IE] && lyc_match) ||
                        (cfg.stat_ie[`STAT_HBLANK_IE] && line.mode == H_BLANK) ||
                        (cfg.stat_ie[`STAT_SCAN_IE] && line.mode == SCAN) ||
                        (cfg.stat_ie[`STAT_VBLANK_IE] && line.mode == V_BLANK));

    assign irq_stat = stat_cond && !stat_q;   // rising edge only

    assign cfg.lcdc    = lcdc_r;
    assign cfg.scx     = scx_r;
    assign cfg.scy     = scy_r;
    assign cfg.stat_ie = stat_ie_r;

endmodule

//--- rtl/lcd_timing.sv
// dot and line sequencer; counters hold at zero while LCDC bit 7 is clear
`timescale 1ns/100ps
`include "ppu_macros.svh"

module lcd_timing
    import ppu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    ppu_cfg_if.sink  cfg,
    line_if.timing   line,
    output logic     irq_vblank
);

    logic [8:0] dot;          // 0..455
    logic [7:0] ly;           // 0..153
    logic       in_draw;      // set at dot 80 of a visible line
    logic       draw_start_q;
    logic       lcd_on;
    logic       line_end;
    logic       visible;
    logic       scan_end;
    ppu_mode_e  mode;

    assign lcd_on   = cfg.lcdc[`LCDC_ENABLE];
    assign line_end = (dot == 9'(`PPU_DOTS_PER_LINE - 1));
    assign visible  = (ly < 8'(`PPU_VISIBLE_LINES));
    assign scan_end = visible && (dot == 9'(`PPU_SCAN_DOTS - 1));

    always_ff @(posedge clk) begin
        if (rst || !lcd_on) begin
            dot          <= '0;
            ly           <= '0;
            in_draw      <= 1'b0;
            draw_start_q <= 1'b0;
            irq_vblank   <= 1'b0;
        end else begin
            draw_start_q <= scan_end;
            // first cycle of line 144
            irq_vblank <= line_end && (ly == 8'(`PPU_VISIBLE_LINES - 1));

            if (line_end) begin
                dot <= '0;
                if (ly == 8'(`PPU_LINES_PER_FRAME - 1))
                    ly <= '0;
                else
                    ly <= ly + 8'd1;
            end else begin
                dot <= dot + 9'd1;
            end

            // draw ends on the shifter's done pulse
            if (scan_end)
                in_draw <= 1'b1;
            else if (line.draw_done || line_end)
                in_draw <= 1'b0;
        end
    end

    always_comb begin
        if (!lcd_on)
            mode = H_BLANK;
        else if (!visible)
            mode = V_BLANK;
        else if (dot < 9'(`PPU_SCAN_DOTS))
            mode = SCAN;
        else if (in_draw)
            mode = DRAW;
        else
            mode = H_BLANK;
    end

    assign line.mode       = mode;
    assign line.ly         = ly;
    assign line.draw_start = draw_start_q;

endmodule

//--- rtl/pixel_shifter.sv
// two-plane pixel shifter; outputs raw 2-bit colour indices with no palette applied
`timescale 1ns/100ps
`include "ppu_macros.svh"

module pixel_shifter
    import ppu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    line_if.shifter    line,
    tile_if.sink       tile,
    output logic [1:0] px,
    output logic       px_valid
);

    logic [7:0] plane_lo;
    logic [7:0] plane_hi;
    logic [2:0] shift_cnt;
    logic [7:0] pix_cnt;       // pixels sent on this line
    logic       draw_done_q;
    logic       empty;
    logic       load;

    // reload in the cycle of the last pixel, so tiles follow back to back
    assign empty = !px_valid || (shift_cnt == 3'd7);
    assign load  = empty && tile.tile_ready && (line.mode == DRAW);

    always_ff @(posedge clk) begin
        if (rst) begin
            px_valid    <= 1'b0;
            shift_cnt   <= '0;
            pix_cnt     <= '0;
            draw_done_q <= 1'b0;
        end else begin
            draw_done_q <= px_valid && (pix_cnt == 8'(`PPU_SCREEN_WIDTH - 1));

            if (line.draw_start)
                pix_cnt <= '0;
            else if (px_valid)
                pix_cnt <= pix_cnt + 8'd1;

            if (line.mode != DRAW) begin
                px_valid <= 1'b0;
            end else if (load) begin
                px_valid  <= 1'b1;
                shift_cnt <= '0;
            end else if (px_valid) begin
                shift_cnt <= shift_cnt + 3'd1;
                if (shift_cnt == 3'd7)
                    px_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            plane_lo <= tile.row_lo;
            plane_hi <= tile.row_hi;
        end else if (px_valid) begin
            plane_lo <= {plane_lo[6:0], 1'b0};   // msb is the leftmost pixel
            plane_hi <= {plane_hi[6:0], 1'b0};
        end
    end

    assign px             = {plane_hi[7], plane_lo[7]};
    assign tile.tile_take = load;
    assign line.draw_done = draw_done_q;

endmodule

//--- rtl/ppu_ifs.sv
// internal bundles of the ppu; draw_start, draw_done and tile_take are single-cycle pulses
`timescale 1ns/100ps

// register settings seen by the pipeline
interface ppu_cfg_if ();
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [6:3] stat_ie;   // same bit numbering as the stat register

    modport source (output lcdc, scx, scy, stat_ie);
    modport sink   (input  lcdc, scx, scy, stat_ie);
endinterface

// line position and draw phase markers
interface line_if import ppu_types_pkg::*; ();
    ppu_mode_e  mode;
    logic [7:0] ly;
    logic       draw_start;   // first cycle of DRAW
    logic       draw_done;    // cycle after the last pixel

    modport timing  (output mode, ly, draw_start, input draw_done);
    modport shifter (input mode, draw_start, output draw_done);
    modport sink    (input mode, ly, draw_start);
endinterface

// one tile row from fetcher to shifter
interface tile_if ();
    logic [7:0] row_lo;
    logic [7:0] row_hi;
    logic       tile_ready;   // rows valid, held until taken
    logic       tile_take;    // shifter loads in this cycle

    modport source (output row_lo, row_hi, tile_ready, input tile_take);
    modport sink   (input row_lo, row_hi, tile_ready, output tile_take);
endinterface

//--- rtl/ppu_macros.svh
// timing and address constants, assumes the standard 160x144 panel and a 456-dot line
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// line and frame timing, in dots and lines
`define PPU_DOTS_PER_LINE     456
`define PPU_SCAN_DOTS         80
`define PPU_VISIBLE_LINES     144
`define PPU_LINES_PER_FRAME   154
`define PPU_SCREEN_WIDTH      160

// vram layout
`define PPU_TILE_BASE_UNSIGNED 16'h8000
`define PPU_TILE_BASE_SIGNED   16'h9000   // tile 0 sits in the middle of the 8800 block
`define PPU_BG_MAP_LO          16'h9800
`define PPU_BG_MAP_HI          16'h9C00

// lcdc bit positions
`define LCDC_ENABLE     7
`define LCDC_TILE_SEL   4
`define LCDC_MAP_SEL    3
`define LCDC_BG_ENABLE  0

// stat interrupt enable bits
`define STAT_LYC_IE     6
`define STAT_SCAN_IE    5
`define STAT_VBLANK_IE  4
`define STAT_HBLANK_IE  3

`endif

//--- rtl/ppu_regs_pkg.sv
// lcd register map; all registers come out of reset as zero, so the display starts off
package ppu_regs_pkg;

    // cpu bus addresses of the lcd registers
    typedef enum logic [15:0] {
        REG_LCDC = 16'hFF40,
        REG_STAT = 16'hFF41,
        REG_SCY  = 16'hFF42,
        REG_SCX  = 16'hFF43,
        REG_LY   = 16'hFF44,   // read only
        REG_LYC  = 16'hFF45,
        REG_DMA  = 16'hFF46,   // storage only
        REG_BGP  = 16'hFF47,
        REG_OBP0 = 16'hFF48,
        REG_OBP1 = 16'hFF49,
        REG_WY   = 16'hFF4A,
        REG_WX   = 16'hFF4B
    } reg_addr_e;

    localparam logic [7:0] REG_RESET_LCDC = 8'h00;
    localparam logic [7:0] REG_RESET_STAT = 8'h00;
    localparam logic [7:0] REG_RESET_SCY  = 8'h00;
    localparam logic [7:0] REG_RESET_SCX  = 8'h00;
    localparam logic [7:0] REG_RESET_LYC  = 8'h00;
    localparam logic [7:0] REG_RESET_DMA  = 8'h00;
    localparam logic [7:0] REG_RESET_BGP  = 8'h00;
    localparam logic [7:0] REG_RESET_OBP0 = 8'h00;
    localparam logic [7:0] REG_RESET_OBP1 = 8'h00;
    localparam logic [7:0] REG_RESET_WY   = 8'h00;
    localparam logic [7:0] REG_RESET_WX   = 8'h00;

endpackage

//--- rtl/ppu_top.sv
// ppu background path top level; vram must answer vram_addr within the same cycle
`timescale 1ns/100ps

module ppu_top (
    input  logic        clk,
    input  logic        rst,

    // cpu register bus
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,

    output logic        irq_vblank,
    output logic        irq_stat,
    output logic [1:0]  mode,

    // vram read port
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,

    // pixel stream
    output logic [1:0]  px,
    output logic        px_valid
);

    ppu_cfg_if cfg ();
    line_if    line ();
    tile_if    tile ();

    assign mode = line.mode;

    lcd_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wr       (wr),
        .rd       (rd),
        .wdata    (wdata),
        .rdata    (rdata),
        .irq_stat (irq_stat),
        .cfg      (cfg.source),
        .line     (line.sink)
    );

    lcd_timing u_timing (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg.sink),
        .line       (line.timing),
        .irq_vblank (irq_vblank)
    );

    bg_fetcher u_fetcher (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg.sink),
        .line      (line.sink),
        .tile      (tile.source),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .vram_data (vram_data)
    );

    pixel_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .line     (line.shifter),
        .tile     (tile.sink),
        .px       (px),
        .px_valid (px_valid)
    );

endmodule

//--- rtl/ppu_types_pkg.sv
// state types shared by the pixel pipeline; mode values match the STAT mode field encoding
package ppu_types_pkg;

    // display mode, encoded as the cpu sees it in stat[1:0]
    typedef enum logic [1:0] {
        H_BLANK = 2'd0,
        V_BLANK = 2'd1,
        SCAN    = 2'd2,
        DRAW    = 2'd3
    } ppu_mode_e;

    // background fetcher steps, one vram read per step except the hold
    typedef enum logic [1:0] {
        MAP_READ,   // tile number from the bg map
        LO_READ,    // low bit-plane of the tile row
        HI_READ,    // high bit-plane
        TILE_HOLD   // row waits for the shifter, or fetcher idle
    } fetch_step_e;

endpackage

//--- tb.f
+incdir+rtl
rtl/ppu_types_pkg.sv
rtl/ppu_regs_pkg.sv
rtl/ppu_ifs.sv
rtl/lcd_regs.sv
rtl/lcd_timing.sv
rtl/bg_fetcher.sv
rtl/pixel_shifter.sv
rtl/ppu_top.sv
dv/ppu_properties.sv
dv/ppu_tb.sv
